/* hw/ej_pkg.sv */
// ========================================
// ej branch core shared types
// opcodes, sequencer states, stack and pc controls
// ========================================
package ej_pkg;

    // java byte values where they exist
    // forth extensions sit in the free 0xcb..0xcf range
    typedef enum logic [7:0] {
        op_nop           = 8'h00,
        op_bipush        = 8'h10,
        op_pop           = 8'h57,
        op_dup           = 8'h59,
        op_ifeq          = 8'h99,
        op_ifne          = 8'h9a,
        op_iflt          = 8'h9b,
        op_ifge          = 8'h9c,
        op_goto          = 8'ha7,
        op_jreturn       = 8'hb1,   // java return
        op_invokevirtual = 8'hb6,
        op_donext        = 8'hcb,
        op_pushr         = 8'hcc,   // t to return stack
        op_popr          = 8'hcd,   // r to data stack
        op_dupr          = 8'hce,   // copy r to data stack
        op_halt          = 8'hcf
    } opcode_t;

    typedef enum logic [1:0] {
        s_op   = 2'd0,      // opcode byte on the bus
        s_arg1 = 2'd1,      // first operand byte
        s_arg2 = 2'd2,      // low address byte
        s_halt = 2'd3
    } seq_state_t;

    typedef enum logic [1:0] {
        stk_nop  = 2'd0,
        stk_push = 2'd1,
        stk_pop  = 2'd2,
        stk_move = 2'd3     // overwrite top in place
    } stk_op_t;

    typedef enum logic [1:0] {
        pc_inc   = 2'd0,
        pc_merge = 2'd1,    // {hi, mem_data}
        pc_rs    = 2'd2,    // return stack top
        pc_hold  = 2'd3
    } pc_src_t;

    // data stack push source
    localparam logic [1:0] sel_mem = 2'd0;  // sign-extended byte
    localparam logic [1:0] sel_rs  = 2'd1;
    localparam logic [1:0] sel_dup = 2'd2;

    typedef struct packed {
        opcode_t    code;
        seq_state_t phase;
        stk_op_t    ds_op;
        logic [1:0] ds_sel;
        logic       latch_hi;
    } seq_ctl_t;

    typedef struct packed {
        logic t_z;
        logic t_neg;
    } ds_flags_t;

    typedef struct packed {
        pc_src_t src;
    } pc_cmd_t;

endpackage

/* hw/ej_seq_fsm.sv */
// ========================================
// ej instruction sequencer
// decodes the opcode byte, walks operand phases
// ========================================
`timescale 1ns/1ps

module ej_seq_fsm
    import ej_pkg::*;
(
    input  logic       ctl,
    input  logic       rst_n,
    input  logic       run,
    input  logic [7:0] mem_data,
    output seq_ctl_t   seq_ctl,
    output logic       halted
);
    seq_state_t state;
    seq_state_t state_n;
    opcode_t    op_q;           // opcode held over the operand bytes
    opcode_t    code;
    logic       three_byte;     // opcode + hi + lo

    // the opcode is live on the bus only in s_op
    assign code = (state == s_op) ? opcode_t'(mem_data) : op_q;

    always_comb begin
        case (code)
            op_ifeq, op_ifne, op_iflt, op_ifge,
            op_goto, op_invokevirtual, op_donext: three_byte = 1'b1;
            default:                              three_byte = 1'b0;
        endcase
    end

    always_comb begin
        state_n = state;
        case (state)
            s_op: begin
                if (code == op_halt)
                    state_n = s_halt;
                else if (three_byte || code == op_bipush)
                    state_n = s_arg1;
            end
            s_arg1:  state_n = three_byte ? s_arg2 : s_op;   // bipush ends here
            s_arg2:  state_n = s_op;
            default: state_n = s_halt;                       // sticky till reset
        endcase
    end

    // data stack control and hi byte strobe
    always_comb begin
        seq_ctl.code     = code;
        seq_ctl.phase    = state;
        seq_ctl.ds_op    = stk_nop;
        seq_ctl.ds_sel   = sel_mem;
        seq_ctl.latch_hi = 1'b0;
        case (state)
            s_op: begin
                case (code)
                    op_pop:   seq_ctl.ds_op = stk_pop;
                    op_pushr: seq_ctl.ds_op = stk_pop;   // t leaves for the return stack
                    op_dup: begin
                        seq_ctl.ds_op  = stk_push;
                        seq_ctl.ds_sel = sel_dup;
                    end
                    op_popr, op_dupr: begin
                        seq_ctl.ds_op  = stk_push;
                        seq_ctl.ds_sel = sel_rs;
                    end
                    default: ;                          // unknown acts as nop
                endcase
            end
            s_arg1: begin
                if (code == op_bipush)
                    seq_ctl.ds_op = stk_push;           // sel_mem, byte sign-extended
                seq_ctl.latch_hi = three_byte;
            end
            s_arg2: begin
                case (code)
                    op_ifeq, op_ifne, op_iflt, op_ifge: seq_ctl.ds_op = stk_pop;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_op;
            op_q  <= op_nop;
        end else if (run) begin
            state <= state_n;
            if (state == s_op)
                op_q <= code;
        end
    end

    assign halted = (state == s_halt);

endmodule

/* hw/ej_pc_counter.sv */
// ========================================
// ej program counter
// increments, merges hi/lo bytes or loads from r
// ========================================
`timescale 1ns/1ps

module ej_pc_counter
    import ej_pkg::*;
#(
    parameter int ASZ = 16,
    parameter int DSZ = 32
) (
    input  logic           ctl,
    input  logic           rst_n,
    input  logic           run,
    input  seq_ctl_t       seq_ctl,
    input  pc_cmd_t        pc_cmd,
    input  logic [7:0]     mem_data,
    input  logic [DSZ-1:0] r,
    output logic [ASZ-1:0] pc
);
    logic [ASZ-9:0] hi;         // upper address bits from the first operand
    logic [ASZ-1:0] pc_n;

    always_comb begin
        case (pc_cmd.src)
            pc_merge: pc_n = {hi, mem_data};    // lo byte is on the bus now
            pc_rs:    pc_n = r[ASZ-1:0];
            pc_hold:  pc_n = pc;
            default:  pc_n = pc + 1'b1;
        endcase
    end

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_n;
        end
    end

    // captured in s_arg1, consumed one cycle later
    always_ff @(posedge ctl) begin
        if (run && seq_ctl.latch_hi) begin
            hi <= mem_data[ASZ-9:0];
        end
    end

endmodule

/* hw/ej_branch_unit.sv */
// ========================================
// ej branch unit
// branch decisions and the return stack
// ========================================
`timescale 1ns/1ps

module ej_branch_unit
    import ej_pkg::*;
#(
    parameter int ASZ      = 16,
    parameter int DSZ      = 32,
    parameter int RS_DEPTH = 16
) (
    input  logic           ctl,
    input  logic           rst_n,
    input  logic           run,
    input  seq_ctl_t       seq_ctl,
    input  ds_flags_t      flags,
    input  logic [DSZ-1:0] t,
    input  logic [ASZ-1:0] pc,
    output pc_cmd_t        pc_cmd,
    output logic [DSZ-1:0] r
);
    localparam int RAW = $clog2(RS_DEPTH);

    logic [DSZ-1:0] rs [RS_DEPTH];  // return stack body
    logic [RAW:0]   rp;             // entry count, 0 = empty
    logic [RAW-1:0] top_idx;
    stk_op_t        rs_op;
    logic [DSZ-1:0] rs_din;
    logic [ASZ-1:0] ret_addr;
    logic           taken;

    assign top_idx  = rp[RAW-1:0] - 1'b1;
    assign r        = (rp == '0) ? '0 : rs[top_idx];   // reads 0 when empty
    assign ret_addr = pc + 1'b1;                       // byte after the lo operand

    // condition per opcode, only looked at in s_arg2
    always_comb begin
        case (seq_ctl.code)
            op_ifeq:   taken = flags.t_z;
            op_ifne:   taken = !flags.t_z;
            op_iflt:   taken = flags.t_neg;
            op_ifge:   taken = !flags.t_neg;
            op_donext: taken = (r != '0);    // loop while count left
            op_goto, op_invokevirtual: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        pc_cmd.src = pc_inc;
        rs_op      = stk_nop;
        rs_din     = t;                      // pushr source
        case (seq_ctl.phase)
            s_op: begin
                case (seq_ctl.code)
                    op_jreturn: begin
                        pc_cmd.src = pc_rs;
                        rs_op      = stk_pop;
                    end
                    op_pushr: rs_op = stk_push;
                    op_popr:  rs_op = stk_pop;
                    op_halt:  pc_cmd.src = pc_hold;   // stay on the halt byte
                    default: ;
                endcase
            end
            s_arg2: begin
                if (taken)
                    pc_cmd.src = pc_merge;
                case (seq_ctl.code)
                    op_invokevirtual: begin
                        rs_op  = stk_push;
                        rs_din = DSZ'(ret_addr);
                    end
                    op_donext: begin
                        // count down in place, drop the counter on exit
                        rs_op  = taken ? stk_move : stk_pop;
                        rs_din = r - 1'b1;
                    end
                    default: ;
                endcase
            end
            s_halt: pc_cmd.src = pc_hold;
            default: ;
        endcase
    end

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            rp <= '0;
        end else if (run) begin
            case (rs_op)
                stk_push: rp <= rp + 1'b1;
                stk_pop:  rp <= rp - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge ctl) begin
        if (run) begin
            case (rs_op)
                stk_push: rs[rp[RAW-1:0]] <= rs_din;   // next free slot
                stk_move: rs[top_idx]     <= rs_din;
                default: ;
            endcase
        end
    end

endmodule

/* hw/ej_data_stack.sv */
// ========================================
// ej data stack
// top register over a small array, t flags
// ========================================
`timescale 1ns/1ps

module ej_data_stack
    import ej_pkg::*;
#(
    parameter int DSZ      = 32,
    parameter int DS_DEPTH = 8
) (
    input  logic           ctl,
    input  logic           rst_n,
    input  logic           run,
    input  seq_ctl_t       seq_ctl,
    input  logic [7:0]     mem_data,
    input  logic [DSZ-1:0] r,
    output logic [DSZ-1:0] t,
    output ds_flags_t      flags
);
    localparam int DAW = $clog2(DS_DEPTH);

    logic [DSZ-1:0] ds [DS_DEPTH];  // entries below t
    logic [DAW:0]   dp;             // entries held in ds
    logic [DAW-1:0] nos_idx;
    logic [DSZ-1:0] nos;            // next on stack
    logic [DSZ-1:0] push_val;

    assign nos_idx = dp[DAW-1:0] - 1'b1;
    assign nos     = (dp == '0) ? '0 : ds[nos_idx];

    always_comb begin
        case (seq_ctl.ds_sel)
            sel_rs:  push_val = r;
            sel_dup: push_val = t;
            default: push_val = {{(DSZ-8){mem_data[7]}}, mem_data};  // bipush
        endcase
    end

    always_ff @(posedge ctl or negedge rst_n) begin
        if (!rst_n) begin
            t  <= '0;
            dp <= '0;
        end else if (run) begin
            case (seq_ctl.ds_op)
                stk_push: begin
                    t  <= push_val;
                    dp <= dp + 1'b1;
                end
                stk_pop: begin
                    t <= nos;                   // empty pop leaves 0
                    if (dp != '0)
                        dp <= dp - 1'b1;
                end
                stk_move: t <= push_val;
                default: ;
            endcase
        end
    end

    // old t sinks into the array on push
    always_ff @(posedge ctl) begin
        if (run && seq_ctl.ds_op == stk_push) begin
            ds[dp[DAW-1:0]] <= t;
        end
    end

    assign flags.t_z   = (t == '0);
    assign flags.t_neg = t[DSZ-1];     // two's complement sign

endmodule

/* hw/ej_branch_core.sv */
// ========================================
// ej branch core top
// sequencer, pc, branch unit and data stack
// ========================================
`timescale 1ns/1ps

module ej_branch_core
    import ej_pkg::*;
#(
    parameter int ASZ      = 16,
    parameter int DSZ      = 32,
    parameter int RS_DEPTH = 16,
    parameter int DS_DEPTH = 8
) (
    input  logic           ctl,
    input  logic           rst_n,
    input  logic           run,
    input  logic [7:0]     mem_data,
    output logic [ASZ-1:0] fetch_addr,
    output logic [DSZ-1:0] tos,
    output logic           halted
);
    seq_ctl_t       seq_ctl;
    ds_flags_t      flags;
    pc_cmd_t        pc_cmd;
    logic [DSZ-1:0] r;          // return stack top

    ej_seq_fsm u_seq (
        .ctl      (ctl),
        .rst_n    (rst_n),
        .run      (run),
        .mem_data (mem_data),
        .seq_ctl  (seq_ctl),
        .halted   (halted)
    );

    ej_pc_counter #(
        .ASZ (ASZ),
        .DSZ (DSZ)
    ) u_pc (
        .ctl      (ctl),
        .rst_n    (rst_n),
        .run      (run),
        .seq_ctl  (seq_ctl),
        .pc_cmd   (pc_cmd),
        .mem_data (mem_data),
        .r        (r),
        .pc       (fetch_addr)  // pc is the fetch address
    );

    ej_branch_unit #(
        .ASZ      (ASZ),
        .DSZ      (DSZ),
        .RS_DEPTH (RS_DEPTH)
    ) u_br (
        .ctl     (ctl),
        .rst_n   (rst_n),
        .run     (run),
        .seq_ctl (seq_ctl),
        .flags   (flags),
        .t       (tos),
        .pc      (fetch_addr),
        .pc_cmd  (pc_cmd),
        .r       (r)
    );

    ej_data_stack #(
        .DSZ      (DSZ),
        .DS_DEPTH (DS_DEPTH)
    ) u_ds (
        .ctl      (ctl),
        .rst_n    (rst_n),
        .run      (run),
        .seq_ctl  (seq_ctl),
        .mem_data (mem_data),
        .r        (r),
        .t        (tos),
        .flags    (flags)
    );

endmodule

/* bench/ej_branch_clkgen.sv */
// ========================================
// testbench clock source
// free-running ctl with a set period
// ========================================
`timescale 1ns/1ps

module ej_branch_clkgen #(
    parameter int PERIOD = 4        // ns
) (
    output logic ctl
);
    initial ctl = 1'b0;

    always #(PERIOD / 2) ctl = ~ctl;    // 50% duty

endmodule

/* bench/ej_branch_assert.sv */
// ========================================
// branch unit and sequencer checkers
// return stack bounds, stall hold, sticky halt
// ========================================
`timescale 1ns/1ps

module ej_branch_assert
    import ej_pkg::*;
#(
    parameter int ASZ      = 16,
    parameter int RS_DEPTH = 16
) (
    input logic                        ctl,
    input logic                        rst_n,
    input logic                        run,
    input seq_ctl_t                    seq_ctl,
    input stk_op_t                     rs_op,
    input logic [$clog2(RS_DEPTH):0]   rp,
    input logic [ASZ-1:0]              pc
);
    localparam int             RAW     = $clog2(RS_DEPTH);
    localparam logic [RAW:0]   RS_FULL = RS_DEPTH[RAW:0];

    // no pop from an empty return stack
    rs_no_underflow: assert property (@(posedge ctl) disable iff (!rst_n)
        (run && rs_op == stk_pop) |-> (rp != '0))
        else $error("return stack popped while empty, rp %h", rp);

    // no push once every slot is used
    rs_no_overflow: assert property (@(posedge ctl) disable iff (!rst_n)
        (run && rs_op == stk_push) |-> (rp != RS_FULL))
        else $error("return stack pushed while full, rp %h", rp);

    // run low freezes the fetch address
    pc_holds_when_stalled: assert property (@(posedge ctl) disable iff (!rst_n)
        !run |=> $stable(pc))
        else $error("pc moved while run was low, pc %h", pc);

    // halt only leaves through reset
    halt_is_sticky: assert property (@(posedge ctl) disable iff (!rst_n)
        (seq_ctl.phase == s_halt) |=> (seq_ctl.phase == s_halt))
        else $error("sequencer left the halt state without a reset");

endmodule

bind ej_branch_unit ej_branch_assert #(
    .ASZ      (ASZ),
    .RS_DEPTH (RS_DEPTH)
) u_br_assert (
    .ctl     (ctl),
    .rst_n   (rst_n),
    .run     (run),
    .seq_ctl (seq_ctl),
    .rs_op   (rs_op),
    .rp      (rp),
    .pc      (pc)
);

/* bench/ej_branch_tb.sv */
// ========================================
// ej branch core testbench
// runs stim programs from a byte memory model
// ========================================
`timescale 1ns/1ps

module ej_branch_tb;
    localparam int         PERIOD     = 4;      // ns
    localparam int         RST_CYCLES = 10;
    localparam int         MEM_SZ     = 256;
    localparam int         STIM_WORDS = 1024;
    localparam int         HDR        = 5;      // count, tos, cycles, halt pc, stall

    logic        ctl;
    logic        rst_n;
    logic        run;
    logic [7:0]  mem_data;
    logic [15:0] fetch_addr;
    logic [31:0] tos;
    logic        halted;

    logic [31:0] stim [STIM_WORDS];     // flat word stream from the stim file
    logic [7:0]  prog_mem [MEM_SZ];     // byte memory seen by the core
    integer      seed;
    int          errors;
    int          checks;
    int          prog_no;
    int          wd_cycles;
    logic        wd_armed;

    ej_branch_clkgen #(.PERIOD(PERIOD)) u_clk (.ctl(ctl));

    ej_branch_core #(
        .ASZ      (16),
        .DSZ      (32),
        .RS_DEPTH (16),
        .DS_DEPTH (8)
    ) UUT (
        .ctl        (ctl),
        .rst_n      (rst_n),
        .run        (run),
        .mem_data   (mem_data),
        .fetch_addr (fetch_addr),
        .tos        (tos),
        .halted     (halted)
    );

    // filler byte mixes every address bit
    function automatic logic [7:0] fill_byte(input logic [15:0] addr);
        fill_byte = addr[15:8] ^ addr[7:0] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] fetch_byte(input logic [15:0] addr);
        if (addr < 16'(MEM_SZ))
            fetch_byte = prog_mem[addr[7:0]];
        else
            fetch_byte = fill_byte(addr);   // past the image
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Mismatch %s in program %0d: got %h expected %h",
                     name, prog_no, got, want);
        end
    endtask

    // called on the falling edge only
    task automatic drive_inputs(input logic stall);
        if (stall)
            run = (($random(seed) & 3) != 0);   // about one cycle in four stalls
        else
            run = 1'b1;
        mem_data = fetch_byte(fetch_addr);
    endtask

    task automatic run_program(input int base);
        int          count;
        logic [31:0] exp_tos;
        int          exp_cycles;
        logic [31:0] exp_pc;
        logic        stall;
        int          run_cycles;

        count      = int'(stim[base]);
        exp_tos    = stim[base + 1];
        exp_cycles = int'(stim[base + 2]);
        exp_pc     = stim[base + 3];
        stall      = stim[base + 4][0];
        prog_no++;
        if (count > MEM_SZ) begin
            errors++;
            $display("program %0d has %0d bytes, more than the byte memory holds",
                     prog_no, count);
            return;
        end
        for (int a = 0; a < MEM_SZ; a++) begin
            prog_mem[a] = fill_byte(16'(a));
        end
        for (int k = 0; k < count; k++) begin
            prog_mem[k] = stim[base + HDR + k][7:0];
        end

        @(negedge ctl);
        rst_n    = 1'b0;
        run      = 1'b0;
        mem_data = 8'h00;
        repeat (RST_CYCLES) @(negedge ctl);
        check_word("fetch_addr", 32'(fetch_addr), 32'h0);   // reset state
        check_word("tos", tos, 32'h0);
        check_word("halted", 32'(halted), 32'h0);

        rst_n = 1'b1;
        drive_inputs(stall);
        run_cycles = 0;
        while (!halted) begin
            @(posedge ctl);
            if (run)
                run_cycles++;               // only enabled edges count
            @(negedge ctl);
            drive_inputs(stall);
        end

        check_word("tos", tos, exp_tos);
        check_word("fetch_addr", 32'(fetch_addr), exp_pc);  // halt byte address
        check_word("run_cycles", 32'(run_cycles), 32'(exp_cycles));
    endtask

    // stops a program that never halts
    initial begin : watchdog
        wait (wd_armed);
        #(wd_cycles * PERIOD);
        $display("watchdog expired after %0d cycles, a program never reached halt",
                 wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        int base;
        int total;
        int nprog;

        rst_n     = 1'b0;
        run       = 1'b0;
        mem_data  = 8'h00;
        seed      = 73;
        errors    = 0;
        checks    = 0;
        prog_no   = 0;
        wd_cycles = 0;
        wd_armed  = 1'b0;
        for (int i = 0; i < STIM_WORDS; i++) begin
            stim[i] = '0;                   // a zero count ends the list
        end
        $readmemh("bench/ej_branch_stim.txt", stim);

        // first pass sizes the watchdog
        base  = 0;
        total = 0;
        nprog = 0;
        while (base < STIM_WORDS - HDR && stim[base] != '0) begin
            total += int'(stim[base + 2]);
            nprog++;
            base += HDR + int'(stim[base]);
        end
        if (nprog == 0) begin
            errors++;
            $display("stim file holds no programs");
        end
        wd_cycles = 2 * total + nprog * (RST_CYCLES + 4);
        wd_armed  = 1'b1;

        base = 0;
        while (base < STIM_WORDS - HDR && stim[base] != '0) begin
            run_program(base);
            base += HDR + int'(stim[base]);
        end

        $display("programs %0d, checks %0d, errors %0d", prog_no, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* bench/ej_branch_stim.txt */
// columns: byte count, expected tos, run cycles to halt, halt address, stall flag,
// then the program bytes from address 0 (all hex)
// straight line bipush, dup, pop
08 ffffff85 08 07 0  10 85 10 7f 59 57 57 cf
// conditional branch on zero, negative, positive
// taken lands on bipush 2 at 0a, fall-through runs bipush 1 and nop
0d 00000002 08 0c 0  10 00 99 00 0a 10 01 00 cf 00 10 02 cf
0d 00000001 09 08 0  10 fd 99 00 0a 10 01 00 cf 00 10 02 cf
0d 00000001 09 08 0  10 05 99 00 0a 10 01 00 cf 00 10 02 cf
0d 00000001 09 08 0  10 00 9a 00 0a 10 01 00 cf 00 10 02 cf
0d 00000002 08 0c 0  10 fd 9a 00 0a 10 01 00 cf 00 10 02 cf
0d 00000002 08 0c 0  10 05 9a 00 0a 10 01 00 cf 00 10 02 cf
0d 00000001 09 08 0  10 00 9b 00 0a 10 01 00 cf 00 10 02 cf
0d 00000002 08 0c 0  10 fd 9b 00 0a 10 01 00 cf 00 10 02 cf
0d 00000001 09 08 0  10 05 9b 00 0a 10 01 00 cf 00 10 02 cf
0d 00000002 08 0c 0  10 00 9c 00 0a 10 01 00 cf 00 10 02 cf
0d 00000001 09 08 0  10 fd 9c 00 0a 10 01 00 cf 00 10 02 cf
0d 00000002 08 0c 0  10 05 9c 00 0a 10 01 00 cf 00 10 02 cf
// call to 0a, subroutine pushes 2a and returns to the pop at 05
0d 00000003 0b 07 0  10 03 b6 00 0a 57 59 cf 00 00 10 2a b1
// pushr, goto over a halt, popr brings 5 back
0b 00000005 0a 0a 0  10 05 cc a7 00 07 cf 10 09 cd cf
// donext loop seeded with 2, body dupr runs three times
0a 00000002 12 09 0  10 02 cc ce cb 00 03 57 57 cf
// same loop and call with run dropped at random
0a 00000002 12 09 1  10 02 cc ce cb 00 03 57 57 cf
0d 00000003 0b 07 1  10 03 b6 00 0a 57 59 cf 00 00 10 2a b1
// end of list
0

/* ej_branch.f */
hw/ej_pkg.sv
hw/ej_seq_fsm.sv
hw/ej_pc_counter.sv
hw/ej_branch_unit.sv
hw/ej_data_stack.sv
hw/ej_branch_core.sv
bench/ej_branch_clkgen.sv
bench/ej_branch_assert.sv
bench/ej_branch_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = ej_branch_tb
FILELIST  = ej_branch.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
